// File: verilog/bus_pkg.sv
/*
 * host register bus definitions
 * request struct, address field helpers and block/offset codes
 */

package bus_pkg;

    typedef logic [15:0] addr_t;
    typedef logic [31:0] data_t;

    // one request per sysclk, no handshake
    typedef struct packed {
        logic  wen;
        addr_t waddr;
        data_t wdata;
        addr_t raddr;
    } reg_bus_t;

    // block code, addr[15:12]
    localparam logic [3:0] ADDR_MAIN = 4'd0;

    // channel 0 holds board regs, 1..4 are axes
    localparam logic [3:0] CHAN_BOARD = 4'd0;

    // offsets, addr[3:0]
    localparam logic [3:0] OFF_ADC_DATA   = 4'd0;
    localparam logic [3:0] OFF_DAC_CTRL   = 4'd1;
    localparam logic [3:0] OFF_BOARD_CTRL = 4'd0;

    function automatic logic [3:0] addr_blk(input addr_t a);
        return a[15:12];
    endfunction

    function automatic logic [3:0] addr_chan(input addr_t a);
        return a[7:4];
    endfunction

    function automatic logic [3:0] addr_off(input addr_t a);
        return a[3:0];
    endfunction

endpackage

// File: verilog/motor_pkg.sv
/*
 * motor axis definitions
 * axis count, current word, board input bundle and safety limits
 */

package motor_pkg;

    localparam int NUM_AXES = 4;

    // unsigned current, same scale for command and feedback
    typedef logic [15:0] cur_t;

    // one bit per axis, bit 0 is axis 1
    typedef logic [NUM_AXES-1:0] axis_mask_t;

    // rotary switch value, already inverted
    typedef logic [3:0] board_id_t;

    // slow board level inputs
    typedef struct packed {
        axis_mask_t fault;
        axis_mask_t home;
        board_id_t  board_id;
    } board_in_t;

    // -----------------------------------------
    // safety limits
    // -----------------------------------------

    // slack added on top of twice the command
    localparam cur_t SAFETY_MARGIN = 16'd64;

    // consecutive overcurrent samples before trip
    localparam int SAFETY_COUNT = 4;
    localparam int SAFETY_CNT_W = $clog2(SAFETY_COUNT + 1);

    typedef logic [SAFETY_CNT_W-1:0] safety_cnt_t;

endpackage

// File: verilog/input_sync.sv
/*
 * two-flop synchronizer for slow asynchronous level inputs
 * payload type set by parameter, both stages reset to zero
 */

`timescale 1ns/100ps

module input_sync #(
    parameter type T = logic
) (
    input  logic sysclk,
    input  logic rst,
    input  T     din,
    output T     dout
);

    // first stage, may go metastable
    T meta;

    always_ff @(posedge sysclk) begin
        if (rst) begin
            meta <= '0;
            dout <= '0;
        end else begin
            meta <= din;
            dout <= meta;
        end
    end

endmodule

// File: verilog/dac_regs.sv
/*
 * per-axis current command registers
 * stores host writes, pulses a per-axis write strobe,
 * reads back command or synchronized feedback
 */

`timescale 1ns/100ps

module dac_regs (
    input  logic                                     sysclk,
    input  logic                                     rst,
    input  bus_pkg::reg_bus_t                        bus,
    input  motor_pkg::cur_t [motor_pkg::NUM_AXES-1:0] fb,
    output bus_pkg::data_t                           rdata,
    output motor_pkg::cur_t [motor_pkg::NUM_AXES-1:0] cmd,
    output motor_pkg::axis_mask_t                    cmd_wr
);

    import bus_pkg::*;
    import motor_pkg::*;

    axis_mask_t wr_sel;
    cur_t       sel_cmd;
    cur_t       sel_fb;
    logic       sel_hit;

    // -----------------------------------------
    // write decode
    // -----------------------------------------

    always_comb begin
        wr_sel = '0;
        if (bus.wen && addr_blk(bus.waddr) == ADDR_MAIN &&
            addr_off(bus.waddr) == OFF_DAC_CTRL) begin
            // channel n maps to axis n-1
            for (int i = 0; i < NUM_AXES; i++) begin
                if (addr_chan(bus.waddr) == 4'(i + 1)) begin
                    wr_sel[i] = 1'b1;
                end
            end
        end
    end

    // new command and strobe appear together
    always_ff @(posedge sysclk) begin
        if (rst) begin
            cmd    <= '0;
            cmd_wr <= '0;
        end else begin
            cmd_wr <= wr_sel;
            for (int i = 0; i < NUM_AXES; i++) begin
                if (wr_sel[i]) begin
                    cmd[i] <= cur_t'(bus.wdata[15:0]);
                end
            end
        end
    end

    // -----------------------------------------
    // readback
    // -----------------------------------------

    always_comb begin
        sel_cmd = '0;
        sel_fb  = '0;
        sel_hit = 1'b0;
        for (int i = 0; i < NUM_AXES; i++) begin
            if (addr_chan(bus.raddr) == 4'(i + 1)) begin
                sel_cmd = cmd[i];
                sel_fb  = fb[i];
                sel_hit = 1'b1;
            end
        end
        // zero-extended, unmapped offsets read zero
        if (!sel_hit) begin
            rdata = '0;
        end else if (addr_off(bus.raddr) == OFF_DAC_CTRL) begin
            rdata = {16'd0, sel_cmd};
        end else if (addr_off(bus.raddr) == OFF_ADC_DATA) begin
            rdata = {16'd0, sel_fb};
        end else begin
            rdata = '0;
        end
    end

endmodule

// File: verilog/safety_check.sv
/*
 * single axis overcurrent detector
 * trips after a run of samples above 2*cmd + margin,
 * latched until the axis command is rewritten
 */

`timescale 1ns/100ps

module safety_check (
    input  logic            sysclk,
    input  logic            rst,
    input  motor_pkg::cur_t cur_fb,
    input  motor_pkg::cur_t cur_cmd,
    input  logic            clear,
    output logic            amp_disable
);

    import motor_pkg::*;

    // two extra bits hold 2*cmd + margin without wrap
    localparam int CMP_W = $bits(cur_t) + 2;

    logic [CMP_W-1:0] limit;
    logic             over;
    safety_cnt_t      cnt;

    // -----------------------------------------
    // threshold compare
    // -----------------------------------------

    always_comb begin
        limit = (CMP_W'(cur_cmd) << 1) + CMP_W'(SAFETY_MARGIN);
        over  = CMP_W'(cur_fb) > limit;
    end

    // -----------------------------------------
    // persistence counter and latch
    // -----------------------------------------

    always_ff @(posedge sysclk) begin
        if (rst) begin
            cnt         <= '0;
            amp_disable <= 1'b0;
        end else if (clear) begin
            // command rewrite, start over
            cnt         <= '0;
            amp_disable <= 1'b0;
        end else begin
            if (!over) begin
                cnt <= '0;
            end else if (cnt != safety_cnt_t'(SAFETY_COUNT)) begin
                cnt <= cnt + 1'b1;
            end
            // this sample completes the run
            if (over && cnt == safety_cnt_t'(SAFETY_COUNT - 1)) begin
                amp_disable <= 1'b1;
            end
        end
    end

endmodule

// File: verilog/board_regs.sv
/*
 * channel 0 board control and status
 * amplifier and power enables, fault/home inputs, board id
 * and safety status readout
 */

`timescale 1ns/100ps

module board_regs (
    input  logic                  sysclk,
    input  logic                  rst,
    input  bus_pkg::reg_bus_t     bus,
    input  motor_pkg::board_in_t  board,
    input  motor_pkg::axis_mask_t safety_amp_disable,
    output bus_pkg::data_t        rdata,
    output motor_pkg::axis_mask_t amp_enable,
    output logic                  pwr_enable
);

    import bus_pkg::*;
    import motor_pkg::*;

    // host requested amp enables before gating
    axis_mask_t amp_req;
    logic       ctrl_wr;
    data_t      status;

    // -----------------------------------------
    // control write
    // -----------------------------------------

    always_comb begin
        ctrl_wr = bus.wen &&
                  addr_blk(bus.waddr) == ADDR_MAIN &&
                  addr_chan(bus.waddr) == CHAN_BOARD &&
                  addr_off(bus.waddr) == OFF_BOARD_CTRL;
    end

    always_ff @(posedge sysclk) begin
        if (rst) begin
            amp_req    <= '0;
            pwr_enable <= 1'b0;
        end else if (ctrl_wr) begin
            amp_req    <= bus.wdata[3:0];
            pwr_enable <= bus.wdata[4];
        end
    end

    // gated enable, one cycle behind request and trip
    always_ff @(posedge sysclk) begin
        if (rst) begin
            amp_enable <= '0;
        end else begin
            amp_enable <= amp_req & {NUM_AXES{pwr_enable}} & ~safety_amp_disable;
        end
    end

    // -----------------------------------------
    // status read
    // -----------------------------------------

    always_comb begin
        status        = '0;
        status[3:0]   = amp_enable;
        status[4]     = pwr_enable;
        status[11:8]  = safety_amp_disable;
        status[15:12] = board.fault;
        status[19:16] = board.home;
        status[27:24] = board.board_id;
        // only the control offset is mapped
        rdata = (addr_off(bus.raddr) == OFF_BOARD_CTRL) ? status : '0;
    end

endmodule

// File: verilog/motor_ctrl_top.sv
/*
 * four-axis motor controller register core
 * input synchronizers, command registers, per-axis safety
 * checks, board registers and the registered read mux
 */

`timescale 1ns/100ps

module motor_ctrl_top (
    input  logic                                      sysclk,
    input  logic                                      rst,
    input  bus_pkg::reg_bus_t                         bus,
    input  motor_pkg::cur_t [motor_pkg::NUM_AXES-1:0] cur_fb,
    input  motor_pkg::axis_mask_t                     fault,
    input  motor_pkg::axis_mask_t                     home,
    input  logic [3:0]                                wenid,
    output bus_pkg::data_t                            reg_rdata,
    output motor_pkg::axis_mask_t                     amp_enable,
    output logic                                      pwr_enable
);

    import bus_pkg::*;
    import motor_pkg::*;

    board_in_t              board_raw;
    board_in_t              board_sync;
    cur_t [NUM_AXES-1:0]    fb_sync;
    cur_t [NUM_AXES-1:0]    cur_cmd;
    axis_mask_t             cmd_wr;
    axis_mask_t             safety_amp_disable;
    data_t                  rdata_dac;
    data_t                  rdata_chan0;
    logic [3:0]             rd_chan;

    // -----------------------------------------
    // input synchronizers
    // -----------------------------------------

    // rotary switch is active low
    assign board_raw = '{fault: fault, home: home, board_id: ~wenid};

    input_sync #(.T(board_in_t)) sync_board (
        .sysclk (sysclk),
        .rst    (rst),
        .din    (board_raw),
        .dout   (board_sync)
    );

    input_sync #(.T(cur_t [NUM_AXES-1:0])) sync_fb (
        .sysclk (sysclk),
        .rst    (rst),
        .din    (cur_fb),
        .dout   (fb_sync)
    );

    // -----------------------------------------
    // command registers, channels 1..4
    // -----------------------------------------

    dac_regs dac (
        .sysclk (sysclk),
        .rst    (rst),
        .bus    (bus),
        .fb     (fb_sync),
        .rdata  (rdata_dac),
        .cmd    (cur_cmd),
        .cmd_wr (cmd_wr)
    );

    // one checker per axis, cleared by its own command write
    for (genvar i = 0; i < NUM_AXES; i++) begin : safe
        safety_check check (
            .sysclk      (sysclk),
            .rst         (rst),
            .cur_fb      (fb_sync[i]),
            .cur_cmd     (cur_cmd[i]),
            .clear       (cmd_wr[i]),
            .amp_disable (safety_amp_disable[i])
        );
    end

    // -----------------------------------------
    // channel 0 board registers
    // -----------------------------------------

    board_regs chan0 (
        .sysclk             (sysclk),
        .rst                (rst),
        .bus                (bus),
        .board              (board_sync),
        .safety_amp_disable (safety_amp_disable),
        .rdata              (rdata_chan0),
        .amp_enable         (amp_enable),
        .pwr_enable         (pwr_enable)
    );

    // -----------------------------------------
    // read mux, block first, then channel
    // -----------------------------------------

    assign rd_chan = addr_chan(bus.raddr);

    always_ff @(posedge sysclk) begin
        if (rst) begin
            reg_rdata <= '0;
        end else if (addr_blk(bus.raddr) != ADDR_MAIN) begin
            reg_rdata <= '0;
        end else if (rd_chan == CHAN_BOARD) begin
            reg_rdata <= rdata_chan0;
        end else if (rd_chan <= 4'(NUM_AXES)) begin
            reg_rdata <= rdata_dac;
        end else begin
            // unused channels
            reg_rdata <= '0;
        end
    end

endmodule

// File: test/tb_clock.sv
/*
 * testbench clock and reset source
 * 100 ns sysclk, reset held for four rising edges
 */

`timescale 1ns/100ps

module tb_clock (
    output logic sysclk,
    output logic rst
);

    initial begin
        sysclk = 1'b0;
        forever #50 sysclk = ~sysclk;
    end

    // release on a falling edge like all other inputs
    initial begin
        rst = 1'b1;
        repeat (4) @(posedge sysclk);
        @(negedge sysclk);
        rst = 1'b0;
    end

endmodule

// File: test/motor_ctrl_sva.sv
/*
 * concurrent checks bound into the register core top
 * amp gating against trips, outputs in reset, other-block reads
 */

`timescale 1ns/100ps

module motor_ctrl_sva (
    input  logic                  sysclk,
    input  logic                  rst,
    input  bus_pkg::reg_bus_t     bus,
    input  bus_pkg::data_t        reg_rdata,
    input  motor_pkg::axis_mask_t amp_enable,
    input  logic                  pwr_enable,
    input  motor_pkg::axis_mask_t safety_amp_disable
);

    import bus_pkg::*;

    // failed assertions so far
    int failures;

    // a tripped axis has its amp off one cycle later
    amp_off_after_trip: assert property (
        @(posedge sysclk) disable iff (rst)
        (amp_enable & $past(safety_amp_disable)) == '0
    ) else begin
        $error("amp_enable high on an axis with safety disable set");
        failures++;
    end

    rst_outputs_low: assert property (
        @(posedge sysclk) rst |=> (amp_enable == '0 && !pwr_enable)
    ) else begin
        $error("enable outputs not low while in reset");
        failures++;
    end

    // only block ADDR_MAIN is decoded
    other_block_reads_zero: assert property (
        @(posedge sysclk) disable iff (rst)
        bus.raddr[15:12] != ADDR_MAIN |=> reg_rdata == '0
    ) else begin
        $error("read of a non-main block returned nonzero data");
        failures++;
    end

endmodule

// File: test/tb_checker.sv
/*
 * reference model and scoreboard for the register core
 * tracks commands, enables, synchronizers and safety latches,
 * compares read data and enable outputs every cycle
 */

`timescale 1ns/100ps

module tb_checker (
    input  logic                                      sysclk,
    input  logic                                      rst,
    input  bus_pkg::reg_bus_t                         bus,
    input  motor_pkg::cur_t [motor_pkg::NUM_AXES-1:0] cur_fb,
    input  motor_pkg::axis_mask_t                     fault,
    input  motor_pkg::axis_mask_t                     home,
    input  logic [3:0]                                wenid,
    input  bus_pkg::data_t                            reg_rdata,
    input  motor_pkg::axis_mask_t                     amp_enable,
    input  logic                                      pwr_enable,
    output int                                        rd_errors,
    output int                                        en_errors
);

    import bus_pkg::*;
    import motor_pkg::*;

    // model state, advanced on each rising edge
    cur_t [NUM_AXES-1:0] m_cmd;
    cur_t [NUM_AXES-1:0] fb_s1;
    cur_t [NUM_AXES-1:0] fb_s2;
    axis_mask_t          m_cmd_wr;
    axis_mask_t          m_req;
    axis_mask_t          m_amp;
    axis_mask_t          m_dis;
    axis_mask_t          flt_s1;
    axis_mask_t          flt_s2;
    axis_mask_t          home_s1;
    axis_mask_t          home_s2;
    logic [3:0]          id_s1;
    logic [3:0]          id_s2;
    logic                m_pwr;
    int                  m_cnt [NUM_AXES];
    data_t               exp_rdata;
    logic                started = 1'b0;

    // expected read value from the current model state
    function automatic data_t model_read(input addr_t a);
        data_t d;
        int    ch;
        d  = '0;
        ch = int'(a[7:4]);
        if (a[15:12] != ADDR_MAIN) begin
            return '0;
        end
        if (ch == 0 && a[3:0] == OFF_BOARD_CTRL) begin
            d[3:0]   = m_amp;
            d[4]     = m_pwr;
            d[11:8]  = m_dis;
            d[15:12] = flt_s2;
            d[19:16] = home_s2;
            d[27:24] = id_s2;
        end else if (ch >= 1 && ch <= NUM_AXES) begin
            if (a[3:0] == OFF_DAC_CTRL) begin
                d[15:0] = m_cmd[ch - 1];
            end else if (a[3:0] == OFF_ADC_DATA) begin
                d[15:0] = fb_s2[ch - 1];
            end
        end
        return d;
    endfunction

    // ----------------------------------------
    // model update
    // ----------------------------------------

    always @(posedge sysclk) begin : model_update
        axis_mask_t  amp_next;
        logic [17:0] limit;
        int          ch;
        if (rst) begin
            m_cmd     = '0;
            fb_s1     = '0;
            fb_s2     = '0;
            m_cmd_wr  = '0;
            m_req     = '0;
            m_amp     = '0;
            m_dis     = '0;
            flt_s1    = '0;
            flt_s2    = '0;
            home_s1   = '0;
            home_s2   = '0;
            id_s1     = '0;
            id_s2     = '0;
            m_pwr     = 1'b0;
            exp_rdata = '0;
            for (int i = 0; i < NUM_AXES; i++) begin
                m_cnt[i] = 0;
            end
            started = 1'b1;
        end else begin
            // everything below reads pre-edge state first
            exp_rdata = model_read(bus.raddr);
            amp_next  = m_req & {NUM_AXES{m_pwr}} & ~m_dis;
            for (int i = 0; i < NUM_AXES; i++) begin
                if (m_cmd_wr[i]) begin
                    // command rewrite releases the latch
                    m_cnt[i] = 0;
                    m_dis[i] = 1'b0;
                end else begin
                    limit = {1'b0, m_cmd[i], 1'b0} + 18'(SAFETY_MARGIN);
                    if ({2'b00, fb_s2[i]} > limit) begin
                        if (m_cnt[i] < SAFETY_COUNT) begin
                            m_cnt[i]++;
                        end
                    end else begin
                        m_cnt[i] = 0;
                    end
                    if (m_cnt[i] == SAFETY_COUNT) begin
                        m_dis[i] = 1'b1;
                    end
                end
            end
            m_amp    = amp_next;
            m_cmd_wr = '0;
            ch       = int'(bus.waddr[7:4]);
            if (bus.wen && bus.waddr[15:12] == ADDR_MAIN) begin
                if (ch >= 1 && ch <= NUM_AXES && bus.waddr[3:0] == OFF_DAC_CTRL) begin
                    m_cmd[ch - 1]    = bus.wdata[15:0];
                    m_cmd_wr[ch - 1] = 1'b1;
                end
                if (ch == 0 && bus.waddr[3:0] == OFF_BOARD_CTRL) begin
                    m_req = bus.wdata[3:0];
                    m_pwr = bus.wdata[4];
                end
            end
            // two-stage synchronizers, id pins are active low
            fb_s2   = fb_s1;
            fb_s1   = cur_fb;
            flt_s2  = flt_s1;
            flt_s1  = fault;
            home_s2 = home_s1;
            home_s1 = home;
            id_s2   = id_s1;
            id_s1   = ~wenid;
        end
    end

    // ----------------------------------------
    // compare on the falling edge
    // ----------------------------------------

    always @(negedge sysclk) begin
        if (started) begin
            if (reg_rdata !== exp_rdata) begin
                rd_errors++;
                $display("Mismatch at %0t: reg_rdata %h, expected %h",
                         $time, reg_rdata, exp_rdata);
            end
            if (amp_enable !== m_amp || pwr_enable !== m_pwr) begin
                en_errors++;
                $display("Mismatch at %0t: amp_enable %b pwr_enable %b, expected %b %b",
                         $time, amp_enable, pwr_enable, m_amp, m_pwr);
            end
        end
    end

endmodule

// File: test/tb_motor_ctrl.sv
/*
 * top testbench for the motor controller register core
 * seeded random register traffic, pin changes and safety trips
 */

`timescale 1ns/100ps

module tb_motor_ctrl;

    import bus_pkg::*;
    import motor_pkg::*;

    localparam int    WAIT_LIMIT  = 40;
    localparam addr_t STATUS_ADDR = 16'h0000;

    logic                sysclk;
    logic                rst;
    reg_bus_t            bus;
    cur_t [NUM_AXES-1:0] cur_fb;
    axis_mask_t          fault;
    axis_mask_t          home;
    logic [3:0]          wenid;
    data_t               reg_rdata;
    axis_mask_t          amp_enable;
    logic                pwr_enable;
    int                  rd_errors;
    int                  en_errors;
    int                  timeouts;
    integer              seed;
    data_t               rd_data;

    tb_clock clk_gen (
        .sysclk (sysclk),
        .rst    (rst)
    );

    motor_ctrl_top DUT (
        .sysclk     (sysclk),
        .rst        (rst),
        .bus        (bus),
        .cur_fb     (cur_fb),
        .fault      (fault),
        .home       (home),
        .wenid      (wenid),
        .reg_rdata  (reg_rdata),
        .amp_enable (amp_enable),
        .pwr_enable (pwr_enable)
    );

    tb_checker check (
        .sysclk     (sysclk),
        .rst        (rst),
        .bus        (bus),
        .cur_fb     (cur_fb),
        .fault      (fault),
        .home       (home),
        .wenid      (wenid),
        .reg_rdata  (reg_rdata),
        .amp_enable (amp_enable),
        .pwr_enable (pwr_enable),
        .rd_errors  (rd_errors),
        .en_errors  (en_errors)
    );

    bind motor_ctrl_top motor_ctrl_sva sva (
        .sysclk             (sysclk),
        .rst                (rst),
        .bus                (bus),
        .reg_rdata          (reg_rdata),
        .amp_enable         (amp_enable),
        .pwr_enable         (pwr_enable),
        .safety_amp_disable (safety_amp_disable)
    );

    // ----------------------------------------
    // bus helpers, called on a falling edge
    // ----------------------------------------

    function automatic addr_t make_addr(input logic [3:0] chan, input logic [3:0] off);
        return {ADDR_MAIN, 4'h0, chan, off};
    endfunction

    task automatic write_reg(input addr_t a, input data_t d);
        bus.wen   = 1'b1;
        bus.waddr = a;
        bus.wdata = d;
        @(negedge sysclk);
        bus.wen   = 1'b0;
    endtask

    // one cycle of read latency
    task automatic read_reg(input addr_t a, output data_t d);
        bus.raddr = a;
        @(negedge sysclk);
        d = reg_rdata;
    endtask

    task automatic idle(input int n);
        repeat (n) @(negedge sysclk);
    endtask

    task automatic wait_reset();
        int n;
        n = 0;
        @(posedge sysclk);
        while (rst && n < WAIT_LIMIT) begin
            @(posedge sysclk);
            n++;
        end
        if (rst) begin
            $display("reset was never released");
            timeouts++;
        end
        @(negedge sysclk);
    endtask

    // ----------------------------------------
    // safety scenarios
    // ----------------------------------------

    // pulses above the limit, each shorter than the trip count
    task automatic toggle_below_count(input int a);
        cur_t c;
        c = 16'($random(seed)) & 16'h03ff;
        write_reg(make_addr(4'(a + 1), OFF_DAC_CTRL), {16'd0, c});
        repeat (6) begin
            cur_fb[a] = (c << 1) + SAFETY_MARGIN + 16'd1;
            idle(SAFETY_COUNT - 1);
            cur_fb[a] = c;
            idle(1);
        end
        read_reg(STATUS_ADDR, rd_data);
        cur_fb[a] = '0;
        idle(3);
    endtask

    task automatic trip_and_clear(input int a);
        cur_t  c;
        data_t d;
        int    n;
        c = 16'($random(seed)) & 16'h03ff;
        write_reg(make_addr(4'(a + 1), OFF_DAC_CTRL), {16'd0, c});
        cur_fb[a] = (c << 1) + SAFETY_MARGIN + 16'(1 + ($random(seed) & 15));
        n = 0;
        d = '0;
        while (!d[8 + a] && n < WAIT_LIMIT) begin
            read_reg(STATUS_ADDR, d);
            n++;
        end
        if (!d[8 + a]) begin
            $display("axis %0d never tripped under sustained overcurrent", a + 1);
            timeouts++;
        end
        // keep the overcurrent well past the count
        idle(4);
        read_reg(make_addr(4'(a + 1), OFF_ADC_DATA), d);
        read_reg(STATUS_ADDR, d);
        // back under the limit, then rewrite the command
        cur_fb[a] = c;
        idle(3);
        write_reg(make_addr(4'(a + 1), OFF_DAC_CTRL), {16'd0, c});
        n = 0;
        while (!amp_enable[a] && n < WAIT_LIMIT) begin
            @(negedge sysclk);
            n++;
        end
        if (!amp_enable[a]) begin
            $display("amp_enable of axis %0d did not return after clear", a + 1);
            timeouts++;
        end
        read_reg(STATUS_ADDR, d);
        cur_fb[a] = '0;
    endtask

    // ----------------------------------------
    // main sequence
    // ----------------------------------------

    initial begin
        seed     = 15;
        bus      = '0;
        cur_fb   = '0;
        fault    = '0;
        home     = '0;
        wenid    = 4'hf;
        timeouts = 0;
        wait_reset();

        // values straight out of reset
        read_reg(STATUS_ADDR, rd_data);
        for (int i = 1; i <= NUM_AXES; i++) begin
            read_reg(make_addr(4'(i), OFF_DAC_CTRL), rd_data);
            read_reg(make_addr(4'(i), OFF_ADC_DATA), rd_data);
        end

        // command writes with junk in the upper half
        for (int k = 0; k < 24; k++) begin
            int   ch;
            cur_t v;
            ch = 1 + ($random(seed) & 3);
            v  = 16'($random(seed));
            write_reg(make_addr(4'(ch), OFF_DAC_CTRL), {16'($random(seed)), v});
            read_reg(make_addr(4'(ch), OFF_DAC_CTRL), rd_data);
            read_reg(16'($random(seed)), rd_data);
            read_reg(make_addr(4'(5 + ($random(seed) & 7)), OFF_DAC_CTRL), rd_data);
            read_reg(make_addr(4'(ch), 4'(2 + ($random(seed) & 7))), rd_data);
        end

        // board pins through the synchronizer
        for (int k = 0; k < 6; k++) begin
            fault = 4'($random(seed));
            home  = 4'($random(seed));
            wenid = 4'($random(seed));
            idle(5);
            read_reg(STATUS_ADDR, rd_data);
        end

        // random enable patterns
        for (int k = 0; k < 8; k++) begin
            write_reg(STATUS_ADDR, 32'($random(seed)));
            idle(2);
            read_reg(STATUS_ADDR, rd_data);
        end

        write_reg(STATUS_ADDR, 32'h0000_001f);
        toggle_below_count($random(seed) & 3);
        trip_and_clear($random(seed) & 3);
        trip_and_clear($random(seed) & 3);
        idle(4);

        $display("errors: %0d read data, %0d enable, %0d timeout, %0d assertion",
                 rd_errors, en_errors, timeouts, DUT.sva.failures);
        if (rd_errors + en_errors + timeouts + DUT.sva.failures == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: build.f
verilog/bus_pkg.sv
verilog/motor_pkg.sv
verilog/input_sync.sv
verilog/dac_regs.sv
verilog/safety_check.sv
verilog/board_regs.sv
verilog/motor_ctrl_top.sv
test/tb_clock.sv
test/motor_ctrl_sva.sv
test/tb_checker.sv
test/tb_motor_ctrl.sv

// File: run.sh
#!/usr/bin/env bash
# build the motor controller testbench with Verilator, run it, check the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -j 0 --top-module tb_motor_ctrl -f build.f \
    && ./obj_dir/Vtb_motor_ctrl +verilator+error+limit+1000 > sim.log 2>&1 \
    || echo "build or simulation did not complete"

cat sim.log 2>/dev/null
grep -qx "Test passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
